// File: logic/compressor_4to2.sv
// One bit of a 4:2 compressor made of two full adders
// cout does not depend on cin, so a row of these never ripples
`timescale 1ns/100ps

module compressor_4to2 (
  input  logic w,
  input  logic x,
  input  logic y,
  input  logic z,
  input  logic cin,
  output logic s,
  output logic c,
  output logic cout
);

  logic s1;

  // First adder on w, x, y
  assign s1   = w ^ x ^ y;
  assign cout = (w & x) | (w & y) | (x & y);

  // Second adder folds in z and the neighbour's cout
  assign s = s1 ^ z ^ cin;
  assign c = (s1 & z) | (s1 & cin) | (z & cin);

endmodule

// File: logic/cs_bus_if.sv
// Registered carry-save pair from the tree to the final adder
// carry is already aligned to its weight, so the value is sum + carry
`timescale 1ns/100ps

interface cs_bus_if import mac_pkg::*; ();

  acc_t sum;
  acc_t carry;
  logic valid;
  logic acc_en;

  modport source (output sum, output carry, output valid, output acc_en);
  modport sink (input sum, input carry, input valid, input acc_en);

endinterface

// File: logic/mac16_top.sv
// Pipelined 16x16 multiply-accumulate, latency 2, one op per cycle
// No back-pressure; out_valid pulses once per accepted in_valid
// md_signed and mr_signed select two's complement per operand
`timescale 1ns/100ps

module mac16_top import mac_pkg::*; (
  input  logic clk,
  input  logic rst_n,
  input  logic in_valid,
  input  logic md_signed,
  input  logic mr_signed,
  input  logic acc_en,
  input  op_t  md,
  input  op_t  mr,
  output acc_t result,
  output logic out_valid
);

  pp_bus_if pp_bus ();
  cs_bus_if cs_bus ();

  acc_t fwd_sum;
  acc_t fwd_carry;

  pp_gen u_pp_gen (
    .clk       (clk),
    .rst_n     (rst_n),
    .in_valid  (in_valid),
    .md_signed (md_signed),
    .mr_signed (mr_signed),
    .acc_en    (acc_en),
    .md        (md),
    .mr        (mr),
    .pp        (pp_bus.source)
  );

  wallace_tree u_tree (
    .clk           (clk),
    .rst_n         (rst_n),
    .pp            (pp_bus.sink),
    .cs            (cs_bus.source),
    .acc           (result),
    .acc_fwd_sum   (fwd_sum),
    .acc_fwd_carry (fwd_carry)
  );

  mac_accumulate u_acc (
    .clk       (clk),
    .rst_n     (rst_n),
    .cs        (cs_bus.sink),
    .result    (result),
    .out_valid (out_valid),
    .fwd_sum   (fwd_sum),
    .fwd_carry (fwd_carry)
  );

endmodule

// File: logic/mac_accumulate.sv
// Final carry-propagate add and accumulator register
// The accumulate term is already inside the pair, so this is a plain add
// Result holds between operations and reads zero after reset
`timescale 1ns/100ps

module mac_accumulate import mac_pkg::*; (
  input  logic clk,
  input  logic rst_n,
  cs_bus_if.sink cs,
  output acc_t result,
  output logic out_valid,
  output acc_t fwd_sum,
  output acc_t fwd_carry
);

  acc_t total;

  assign total = cs.sum + cs.carry;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      result    <= '0;
      out_valid <= 1'b0;
    end else begin
      out_valid <= cs.valid;
      if (cs.valid) begin
        result <= total;
      end
    end
  end

  // Pending pair for an op one cycle behind that accumulates onto it
  assign fwd_sum   = cs.sum;
  assign fwd_carry = cs.carry;

  a_result_known: assert property (
    @(posedge clk) disable iff (!rst_n) out_valid |-> !$isunknown(result)
  );

endmodule

// File: logic/mac_pkg.sv
// Shared widths and vector types for the 16x16 MAC
// The tree layout below assumes 16 rows reduced in four levels of 4:2 compressors
package mac_pkg;

  localparam int OP_W   = 16;
  localparam int ACC_W  = 32;
  localparam int N_ROWS = OP_W;

  typedef logic [OP_W-1:0]  op_t;
  typedef logic [ACC_W-1:0] row_t;
  typedef logic [ACC_W-1:0] acc_t;

  // ************************************************************
  // Wallace tree node map
  // ************************************************************
  // Level lv runs TREE_LEVELS-lv groups of four vectors into two each.
  // Inputs of level lv start at tree_base(lv), outputs at tree_base(lv+1).
  //   0..15  rows          16..23 level 1 out
  //   24     corr          25..26 feedback pair, 27 zero
  //   28..33 level 2 out   34..35 zero
  //   36..39 level 3 out   40..41 final pair
  localparam int TREE_LEVELS = 4;
  localparam int TREE_NODES  = 42;

  function automatic int tree_base(int lv);
    return 4 * TREE_LEVELS * lv - 2 * lv * (lv - 1);
  endfunction

endpackage

// File: logic/pp_bus_if.sv
// Partial-product rows from pp_gen to the Wallace tree
// Rows and corr are only meaningful while valid is high
`timescale 1ns/100ps

interface pp_bus_if import mac_pkg::*; ();

  row_t rows [N_ROWS];
  // Sign correction constant plus the two's-complement increment
  row_t corr;
  logic valid;
  logic acc_en;

  modport source (
    output rows,
    output corr,
    output valid,
    output acc_en
  );

  modport sink (
    input rows,
    input corr,
    input valid,
    input acc_en
  );

endinterface

// File: logic/pp_gen.sv
// Operand register and partial-product generation
// Operands are taken only on in_valid; rows follow the registered values
// Signed md flips each row's top bit, signed mr inverts the top row
`timescale 1ns/100ps

module pp_gen import mac_pkg::*; (
  input  logic clk,
  input  logic rst_n,
  input  logic in_valid,
  input  logic md_signed,
  input  logic mr_signed,
  input  logic acc_en,
  input  op_t  md,
  input  op_t  mr,
  pp_bus_if.source pp
);

  logic valid_q;
  logic md_signed_q;
  logic mr_signed_q;
  logic acc_en_q;
  op_t  md_q;
  op_t  mr_q;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      valid_q <= 1'b0;
    end else begin
      valid_q <= in_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (in_valid) begin
      md_q        <= md;
      mr_q        <= mr;
      md_signed_q <= md_signed;
      mr_signed_q <= mr_signed;
      acc_en_q    <= acc_en;
    end
  end

  // ************************************************************
  // Row formation
  // ************************************************************
  always_comb begin : rows_comb
    op_t  part;
    row_t row;
    for (int i = 0; i < N_ROWS; i++) begin
      part = md_q & {OP_W{mr_q[i]}};
      part[OP_W-1] = part[OP_W-1] ^ md_signed_q;
      row = {{(ACC_W-OP_W){1'b0}}, part} << i;
      // Negative weight of mr's sign bit, the +1 lives in corr
      if (i == N_ROWS - 1 && mr_signed_q) begin
        row = ~row;
      end
      pp.rows[i] = row;
    end
  end

  // Sum of the flipped-bit offsets, adjusted when the top row is negated
  always_comb begin
    case ({md_signed_q, mr_signed_q})
      2'b10:   pp.corr = 32'h8000_8000;
      2'b11:   pp.corr = 32'h0000_8001;
      2'b01:   pp.corr = 32'h0000_0001;
      default: pp.corr = '0;
    endcase
  end

  assign pp.valid  = valid_q;
  assign pp.acc_en = acc_en_q;

  a_valid_known: assert property (
    @(posedge clk) disable iff (!rst_n) !$isunknown(valid_q)
  );

endmodule

// File: logic/wallace_tree.sv
// Four-level 4:2 compressor tree over the rows, corr and accumulator feedback
// Result is a registered carry-save pair mod 2^32
// When accumulating behind a pending op, that op's pair is used instead of acc
`timescale 1ns/100ps

module wallace_tree import mac_pkg::*; (
  input  logic clk,
  input  logic rst_n,
  pp_bus_if.sink   pp,
  cs_bus_if.source cs,
  input  acc_t acc,
  input  acc_t acc_fwd_sum,
  input  acc_t acc_fwd_carry
);

  wire acc_t node [TREE_NODES];

  acc_t fb_sum;
  acc_t fb_carry;
  logic valid_q;
  logic acc_en_q;
  acc_t sum_q;
  acc_t carry_q;
  acc_t tree_in_total;

  // ************************************************************
  // Tree inputs
  // ************************************************************
  for (genvar r = 0; r < N_ROWS; r++) begin : g_rows
    assign node[r] = pp.rows[r];
  end

  // Previous result in issue order is still in carry-save form while pending
  always_comb begin
    fb_sum   = '0;
    fb_carry = '0;
    if (pp.acc_en) begin
      if (valid_q) begin
        fb_sum   = acc_fwd_sum;
        fb_carry = acc_fwd_carry;
      end else begin
        fb_sum = acc;
      end
    end
  end

  assign node[24] = pp.corr;
  assign node[25] = fb_sum;
  assign node[26] = fb_carry;

  // Unused group slots
  assign node[27] = '0;
  assign node[34] = '0;
  assign node[35] = '0;

  // ************************************************************
  // Compressor levels
  // ************************************************************
  for (genvar lv = 0; lv < TREE_LEVELS; lv++) begin : g_level
    for (genvar g = 0; g < TREE_LEVELS - lv; g++) begin : g_group
      acc_t s_vec;
      acc_t c_vec;
      acc_t co_vec;
      acc_t ci_vec;

      // The sideways carry out of bit 31 drops off mod 2^32
      assign ci_vec = {co_vec[ACC_W-2:0], 1'b0};

      for (genvar b = 0; b < ACC_W; b++) begin : g_bit
        compressor_4to2 u_cmp (
          .w    (node[tree_base(lv) + 4*g][b]),
          .x    (node[tree_base(lv) + 4*g + 1][b]),
          .y    (node[tree_base(lv) + 4*g + 2][b]),
          .z    (node[tree_base(lv) + 4*g + 3][b]),
          .cin  (ci_vec[b]),
          .s    (s_vec[b]),
          .c    (c_vec[b]),
          .cout (co_vec[b])
        );
      end

      assign node[tree_base(lv+1) + 2*g]     = s_vec;
      assign node[tree_base(lv+1) + 2*g + 1] = {c_vec[ACC_W-2:0], 1'b0};
    end
  end

  // ************************************************************
  // Carry-save register
  // ************************************************************
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      valid_q <= 1'b0;
    end else begin
      valid_q <= pp.valid;
    end
  end

  always_ff @(posedge clk) begin
    if (pp.valid) begin
      sum_q    <= node[TREE_NODES-2];
      carry_q  <= node[TREE_NODES-1];
      acc_en_q <= pp.acc_en;
    end
  end

  assign cs.sum    = sum_q;
  assign cs.carry  = carry_q;
  assign cs.valid  = valid_q;
  assign cs.acc_en = acc_en_q;

  // Plain sum of everything that enters the tree
  always_comb begin
    tree_in_total = pp.corr + fb_sum + fb_carry;
    for (int r = 0; r < N_ROWS; r++) begin
      tree_in_total = tree_in_total + pp.rows[r];
    end
  end

  a_cs_follows_pp: assert property (
    @(posedge clk) disable iff (!rst_n)
    pp.valid |=> (cs.valid && (cs.sum + cs.carry == $past(tree_in_total)))
  );

endmodule

// File: project.f
+incdir+tb
logic/mac_pkg.sv
logic/pp_bus_if.sv
logic/cs_bus_if.sv
logic/compressor_4to2.sv
logic/pp_gen.sv
logic/wallace_tree.sv
logic/mac_accumulate.sv
logic/mac16_top.sv
tb/tb_mac16.sv

// File: tb/mac16_tests.svh
// Directed tests for mac16_top, included inside tb_mac16
// Every task starts and ends on a falling clock edge

// ************************************************************
// Stimulus helpers
// ************************************************************
// Drives one operation for one cycle and queues its expected result
task automatic issue_op(input op_t a, input op_t b, input logic a_s,
                        input logic b_s, input logic ae);
  acc_t prod;
  prod = model_product(a, b, a_s, b_s);
  model_acc = (ae ? model_acc : '0) + prod;
  exp_q.push_back(model_acc);
  // Counted from the edge that samples in_valid
  due_q.push_back(cycle + 1 + LATENCY);
  md        = a;
  mr        = b;
  md_signed = a_s;
  mr_signed = b_s;
  acc_en    = ae;
  in_valid  = 1'b1;
  @(negedge clk);
endtask

task automatic idle_cycles(input int n);
  in_valid = 1'b0;
  repeat (n) @(negedge clk);
endtask

task automatic wait_drain();
  in_valid = 1'b0;
  while (due_q.size() != 0) begin
    @(negedge clk);
  end
endtask

// ************************************************************
// Tests
// ************************************************************
task automatic test_reset_state();
  repeat (5) begin
    check_valid(out_valid, 1'b0, "out_valid after reset");
    check_result(result, '0, "result after reset");
    @(negedge clk);
  end
endtask

// One op at a time so that each latency is seen on its own
task automatic test_unsigned_corners();
  issue_op(16'h0000, 16'h0000, 1'b0, 1'b0, 1'b0);
  wait_drain();
  issue_op(16'h0000, 16'hFFFF, 1'b0, 1'b0, 1'b0);
  wait_drain();
  issue_op(16'h0001, 16'h0001, 1'b0, 1'b0, 1'b0);
  wait_drain();
  issue_op(16'h0001, 16'hFFFF, 1'b0, 1'b0, 1'b0);
  wait_drain();
  issue_op(16'hFFFF, 16'hFFFF, 1'b0, 1'b0, 1'b0);
  wait_drain();
  issue_op(16'h8000, 16'h0002, 1'b0, 1'b0, 1'b0);
  wait_drain();
  issue_op(16'h1234, 16'h5678, 1'b0, 1'b0, 1'b0);
  wait_drain();
endtask

task automatic test_signed_products();
  issue_op(16'h8000, 16'h8000, 1'b1, 1'b1, 1'b0);
  issue_op(16'h7FFF, 16'h7FFF, 1'b1, 1'b1, 1'b0);
  issue_op(16'h8000, 16'h7FFF, 1'b1, 1'b1, 1'b0);
  issue_op(16'hFFFF, 16'hFFFF, 1'b1, 1'b1, 1'b0);
  issue_op(16'hFFFF, 16'h0001, 1'b1, 1'b1, 1'b0);
  // Mixed signs, -1 times 65535 both ways round
  issue_op(16'hFFFF, 16'hFFFF, 1'b1, 1'b0, 1'b0);
  issue_op(16'hFFFF, 16'hFFFF, 1'b0, 1'b1, 1'b0);
  issue_op(16'h7FFF, 16'h8000, 1'b0, 1'b1, 1'b0);
  issue_op(16'h8000, 16'hFFFF, 1'b1, 1'b0, 1'b0);
  wait_drain();
endtask

task automatic test_accumulate();
  // Spaced ops read the registered accumulator
  issue_op(16'hFFFF, 16'hFFFF, 1'b0, 1'b0, 1'b0);
  idle_cycles(3);
  issue_op(16'hFFFF, 16'hFFFF, 1'b0, 1'b0, 1'b1);
  idle_cycles(3);
  issue_op(16'h8000, 16'h7FFF, 1'b1, 1'b1, 1'b1);
  idle_cycles(3);
  issue_op(16'h1234, 16'h0010, 1'b0, 1'b0, 1'b1);
  wait_drain();
  // One idle cycle between dependent ops
  issue_op(16'hFFFF, 16'hFFFF, 1'b0, 1'b0, 1'b1);
  idle_cycles(1);
  issue_op(16'hFFFF, 16'hFFFF, 1'b0, 1'b0, 1'b1);
  idle_cycles(1);
  issue_op(16'hFFFF, 16'h0003, 1'b1, 1'b0, 1'b1);
  wait_drain();
  // Back to back, the forward path carries each sum
  issue_op(16'hFFFF, 16'hFFFF, 1'b0, 1'b0, 1'b1);
  issue_op(16'hFFFF, 16'hFFFF, 1'b0, 1'b0, 1'b1);
  issue_op(16'h8000, 16'h8000, 1'b1, 1'b1, 1'b1);
  issue_op(16'h0003, 16'h0005, 1'b0, 1'b0, 1'b0);
  issue_op(16'h0007, 16'h0002, 1'b0, 1'b0, 1'b1);
  issue_op(16'hFFFE, 16'h0004, 1'b1, 1'b0, 1'b1);
  wait_drain();
endtask

task automatic test_random_stream();
  op_t  a;
  op_t  b;
  logic a_s;
  logic b_s;
  logic ae;
  for (int n = 0; n < STREAM_OPS; n++) begin
    a   = op_t'($random(seed));
    b   = op_t'($random(seed));
    a_s = 1'($random(seed));
    b_s = 1'($random(seed));
    // Mostly accumulating, so long dependent runs occur
    ae  = (($random(seed) & 3) != 0);
    issue_op(a, b, a_s, b_s, ae);
  end
  wait_drain();
endtask

// File: tb/tb_mac16.sv
// Testbench for mac16_top that stops at the first mismatch
// Expected results come from a behavioural model and are checked in issue order
// out_valid is checked every cycle against the fixed latency of 2
`timescale 1ns/100ps

module tb_mac16 import mac_pkg::*; ();

  localparam int LATENCY = 2;
  // Well above the roughly 500 cycles the tests need
  localparam int TIMEOUT_CYCLES = 2000;
  localparam int STREAM_OPS = 400;

  logic clk = 1'b0;
  logic rst_n;
  logic in_valid;
  logic md_signed;
  logic mr_signed;
  logic acc_en;
  op_t  md;
  op_t  mr;
  acc_t result;
  logic out_valid;

  int   cycle = 0;
  int   seed = 32'h0456_0c5c;
  acc_t model_acc = '0;
  acc_t exp_q [$];
  int   due_q [$];
  logic exp_valid;

  mac16_top DUT (
    .clk       (clk),
    .rst_n     (rst_n),
    .in_valid  (in_valid),
    .md_signed (md_signed),
    .mr_signed (mr_signed),
    .acc_en    (acc_en),
    .md        (md),
    .mr        (mr),
    .result    (result),
    .out_valid (out_valid)
  );

  always #5 clk = ~clk;

  always @(posedge clk) begin
    cycle <= cycle + 1;
  end

  // ************************************************************
  // Reference model and compare tasks
  // ************************************************************
  // Exact product mod 2^32 of the operands read per their flags
  function automatic acc_t model_product(op_t a, op_t b, logic a_s, logic b_s);
    acc_t ax;
    acc_t bx;
    ax = a_s ? {{(ACC_W-OP_W){a[OP_W-1]}}, a} : {{(ACC_W-OP_W){1'b0}}, a};
    bx = b_s ? {{(ACC_W-OP_W){b[OP_W-1]}}, b} : {{(ACC_W-OP_W){1'b0}}, b};
    return ax * bx;
  endfunction

  task automatic report_failure(input string line);
    $display("%s", line);
    $display("ERRORS FOUND");
    $fatal(1);
  endtask

  task automatic check_result(input acc_t got, input acc_t exp, input string what);
    if (got !== exp) begin
      report_failure($sformatf("error at %0t ns: %s is %h, expected %h",
                               $time, what, got, exp));
    end
  endtask

  task automatic check_valid(input logic got, input logic exp, input string what);
    if (got !== exp) begin
      report_failure($sformatf("error at %0t ns: %s is %b, expected %b",
                               $time, what, got, exp));
    end
  endtask

  // Output monitor sampled on the falling edge
  always @(negedge clk) begin
    exp_valid = (due_q.size() > 0) && (due_q[0] == cycle);
    check_valid(out_valid, exp_valid, "out_valid");
    if (exp_valid) begin
      check_result(result, exp_q.pop_front(), "result");
      void'(due_q.pop_front());
    end
  end

  always @(posedge clk) begin
    if (cycle >= TIMEOUT_CYCLES) begin
      report_failure($sformatf("Run did not finish within %0d cycles", TIMEOUT_CYCLES));
    end
  end

  `include "mac16_tests.svh"

  initial begin
    rst_n     = 1'b0;
    in_valid  = 1'b0;
    md_signed = 1'b0;
    mr_signed = 1'b0;
    acc_en    = 1'b0;
    md        = '0;
    mr        = '0;
    repeat (8) @(negedge clk);
    rst_n = 1'b1;

    test_reset_state();
    test_unsigned_corners();
    test_signed_products();
    test_accumulate();
    test_random_stream();

    $display("NO ERRORS");
    $finish;
  end

endmodule
